/* hdl/rotate_pkg.sv */
// shared rotation, phase and degree types plus tile geometry, imported by the rotation RTL
`default_nettype none

package rotate_pkg;

    // bytes of one RGB pixel, R first
    localparam int BYTES_PER_PIXEL = 3;

    // output buffer is written one word at a time
    localparam int WORD_BYTES = 4;

    // tile edge in pixels, 4 and 16 also work
    localparam int TILE_DIM_DEFAULT = 8;

    // rotation applied to the whole tile
    typedef enum logic [1:0]
    {
        ROT_0     = 2'd0,
        ROT_CW90  = 2'd1,
        ROT_180   = 2'd2,
        ROT_CCW90 = 2'd3
    } rot_mode_t;

    // sequencer state
    typedef enum logic [1:0]
    {
        PH_IDLE  = 2'd0,
        PH_READ  = 2'd1,
        PH_WRITE = 2'd2
    } phase_t;

    // degrees input code, direction picks the sense of 90 and 270
    typedef enum logic [1:0]
    {
        DEG_0   = 2'd0,
        DEG_90  = 2'd1,
        DEG_180 = 2'd2,
        DEG_270 = 2'd3
    } deg_t;

endpackage

`default_nettype wire

/* hdl/tile_sequencer.sv */
// tile phase FSM: counts DMA beats, captures the rotation per tile and drives the write word address
`default_nettype none

module tile_sequencer
#(
    parameter  int TILE_DIM = rotate_pkg::TILE_DIM_DEFAULT,
    localparam int PIXELS   = TILE_DIM * TILE_DIM,
    localparam int WORDS    = PIXELS * rotate_pkg::BYTES_PER_PIXEL / rotate_pkg::WORD_BYTES,
    localparam int WORD_W   = $clog2(WORDS)
)
(
    input  logic                  I_CP_HCLK,
    input  logic                  I_CP_HRESET_N,
    input  logic                  dma_ready,
    input  logic                  direction,
    input  rotate_pkg::deg_t      degrees,
    output logic                  read_active,
    output logic                  write_active,
    output logic                  tile_start,
    output logic                  read_beat,
    output rotate_pkg::rot_mode_t rot_mode,
    output logic [WORD_W-1:0]     word_addr
);

    import rotate_pkg::*;

    // one counter serves both phases, read is the longer one
    localparam int CNT_W = $clog2(PIXELS);
    localparam logic [CNT_W-1:0] READ_LAST  = CNT_W'(PIXELS - 1);
    localparam logic [CNT_W-1:0] WRITE_LAST = CNT_W'(WORDS - 1);

    phase_t           phase_q;
    phase_t           phase_d;
    logic [CNT_W-1:0] beat_cnt_q;
    logic             beat;
    logic             last_beat;
    rot_mode_t        rot_q;
    rot_mode_t        rot_dec;

    // a beat needs an active phase, the idle exit is not one
    assign beat = dma_ready && (phase_q != PH_IDLE);

    assign last_beat = (phase_q == PH_READ) ? (beat_cnt_q == READ_LAST)
                                            : (beat_cnt_q == WRITE_LAST);

    always_comb
    begin
        phase_d = phase_q;
        case (phase_q)
            PH_IDLE:
                if (dma_ready)
                    phase_d = PH_READ;
            PH_READ:
                if (beat && last_beat)
                    phase_d = PH_WRITE;
            PH_WRITE:
                if (beat && last_beat)
                    phase_d = PH_READ;
            default:
                phase_d = PH_IDLE;
        endcase
    end

    always_ff @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N)
            phase_q <= PH_IDLE;
        else
            phase_q <= phase_d;
    end

    // restarts at every phase change, so it is also the word index
    always_ff @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N)
            beat_cnt_q <= '0;
        else if (beat)
        begin
            if (last_beat)
                beat_cnt_q <= '0;
            else
                beat_cnt_q <= beat_cnt_q + 1'b1;
        end
    end

    // direction high means counter-clockwise
    always_comb
    begin
        case (degrees)
            DEG_90:  rot_dec = direction ? ROT_CCW90 : ROT_CW90;
            DEG_180: rot_dec = ROT_180;
            DEG_270: rot_dec = direction ? ROT_CW90 : ROT_CCW90;
            default: rot_dec = ROT_0;
        endcase
    end

    // entering read from idle or from write starts a tile
    assign tile_start = (phase_q != PH_READ) && (phase_d == PH_READ);

    always_ff @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N)
            rot_q <= ROT_0;
        else if (tile_start)
            rot_q <= rot_dec;
    end

    // the new mode is shown on the load edge itself so start values match it
    assign rot_mode = tile_start ? rot_dec : rot_q;

    assign read_active  = (phase_q == PH_READ);
    assign write_active = (phase_q == PH_WRITE);
    assign read_beat    = read_active && dma_ready;
    assign word_addr    = write_active ? beat_cnt_q[WORD_W-1:0] : '0;

endmodule

`default_nettype wire

/* hdl/pixel_addr_rotator.sv */
// read-phase byte addresses: input pixel R byte and its rotated position in the output buffer
`default_nettype none

module pixel_addr_rotator
#(
    parameter  int TILE_DIM = rotate_pkg::TILE_DIM_DEFAULT,
    localparam int ADDR_W   = $clog2(TILE_DIM * TILE_DIM * rotate_pkg::BYTES_PER_PIXEL)
)
(
    input  logic                  I_CP_HCLK,
    input  logic                  I_CP_HRESET_N,
    input  logic                  tile_start,
    input  logic                  read_beat,
    input  rotate_pkg::rot_mode_t rot_mode,
    output logic [ADDR_W-1:0]     src_addr,
    output logic [ADDR_W-1:0]     dst_addr
);

    import rotate_pkg::*;

    localparam int COL_W = $clog2(TILE_DIM);
    localparam logic [COL_W-1:0] COL_LAST = COL_W'(TILE_DIM - 1);

    // one pixel and one full row of pixels, in bytes
    localparam logic [ADDR_W-1:0] PIX_STEP = ADDR_W'(BYTES_PER_PIXEL);
    localparam logic [ADDR_W-1:0] ROW_STEP = ADDR_W'(BYTES_PER_PIXEL * TILE_DIM);

    // destination of input pixel 0 for each rotation
    localparam logic [ADDR_W-1:0] START_180 =
        ADDR_W'(BYTES_PER_PIXEL * (TILE_DIM * TILE_DIM - 1));
    localparam logic [ADDR_W-1:0] START_CW =
        ADDR_W'(BYTES_PER_PIXEL * (TILE_DIM - 1));
    localparam logic [ADDR_W-1:0] START_CCW =
        ADDR_W'(BYTES_PER_PIXEL * TILE_DIM * (TILE_DIM - 1));

    logic [ADDR_W-1:0] src_q;
    logic [ADDR_W-1:0] dst_q;
    logic [ADDR_W-1:0] dst_d;
    logic [ADDR_W-1:0] base_q;
    logic [ADDR_W-1:0] base_d;
    logic [ADDR_W-1:0] start_addr;
    logic [COL_W-1:0]  col_q;
    logic              row_end;

    always_comb
    begin
        case (rot_mode)
            ROT_180:   start_addr = START_180;
            ROT_CW90:  start_addr = START_CW;
            ROT_CCW90: start_addr = START_CCW;
            default:   start_addr = '0;
        endcase
    end

    // last input column of the current row
    assign row_end = (col_q == COL_LAST);

    always_comb
    begin
        dst_d  = dst_q;
        base_d = base_q;
        case (rot_mode)
            ROT_0:
                dst_d = dst_q + PIX_STEP;
            ROT_180:
                dst_d = dst_q - PIX_STEP;
            // input row becomes an output column, walking down it
            ROT_CW90:
                if (row_end)
                begin
                    base_d = base_q - PIX_STEP;
                    dst_d  = base_q - PIX_STEP;
                end
                else
                    dst_d = dst_q + ROW_STEP;
            // same idea walking up, columns move right
            ROT_CCW90:
                if (row_end)
                begin
                    base_d = base_q + PIX_STEP;
                    dst_d  = base_q + PIX_STEP;
                end
                else
                    dst_d = dst_q - ROW_STEP;
            default:
                dst_d = dst_q;
        endcase
    end

    // beyond the last beat the values run on unused until the next tile load
    always_ff @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N)
        begin
            src_q  <= '0;
            dst_q  <= '0;
            base_q <= '0;
            col_q  <= '0;
        end
        else if (tile_start)
        begin
            src_q  <= '0;
            dst_q  <= start_addr;
            base_q <= start_addr;
            col_q  <= '0;
        end
        else if (read_beat)
        begin
            src_q  <= src_q + PIX_STEP;
            dst_q  <= dst_d;
            base_q <= base_d;
            col_q  <= row_end ? '0 : col_q + 1'b1;
        end
    end

    assign src_addr = src_q;
    assign dst_addr = dst_q;

endmodule

`default_nettype wire

/* hdl/rotate_addr_gen.sv */
// top level of the tile rotation address generator, the block a DMA-driven buffer system instantiates
`default_nettype none

module rotate_addr_gen
#(
    parameter  int TILE_DIM = rotate_pkg::TILE_DIM_DEFAULT,
    localparam int PIXELS   = TILE_DIM * TILE_DIM,
    localparam int ADDR_W   = $clog2(PIXELS * rotate_pkg::BYTES_PER_PIXEL),
    localparam int WORD_W   =
        $clog2(PIXELS * rotate_pkg::BYTES_PER_PIXEL / rotate_pkg::WORD_BYTES)
)
(
    input  logic              I_CP_HCLK,
    input  logic              I_CP_HRESET_N,
    input  logic              dma_ready,
    input  logic              direction,
    input  rotate_pkg::deg_t  degrees,
    output logic              read_active,
    output logic              write_active,
    output logic [ADDR_W-1:0] src_addr,
    output logic [ADDR_W-1:0] dst_addr,
    output logic [WORD_W-1:0] word_addr
);

    import rotate_pkg::*;

    logic      tile_start;
    logic      read_beat;
    rot_mode_t rot_mode;

    // phases, beat count and mode capture
    tile_sequencer
    #(
        .TILE_DIM      (TILE_DIM)
    )
    u_sequencer
    (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .dma_ready     (dma_ready),
        .direction     (direction),
        .degrees       (degrees),
        .read_active   (read_active),
        .write_active  (write_active),
        .tile_start    (tile_start),
        .read_beat     (read_beat),
        .rot_mode      (rot_mode),
        .word_addr     (word_addr)
    );

    // per-pixel source and rotated destination
    pixel_addr_rotator
    #(
        .TILE_DIM      (TILE_DIM)
    )
    u_rotator
    (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .tile_start    (tile_start),
        .read_beat     (read_beat),
        .rot_mode      (rot_mode),
        .src_addr      (src_addr),
        .dst_addr      (dst_addr)
    );

endmodule

`default_nettype wire

/* tb/rotate_checker.sv */
// scoreboard for the rotation address generator, models phases and beats and compares every cycle
`default_nettype none

module rotate_checker
#(
    parameter  int TILE_DIM = rotate_pkg::TILE_DIM_DEFAULT,
    localparam int PIXELS   = TILE_DIM * TILE_DIM,
    localparam int WORDS    = PIXELS * rotate_pkg::BYTES_PER_PIXEL / rotate_pkg::WORD_BYTES,
    localparam int ADDR_W   = $clog2(PIXELS * rotate_pkg::BYTES_PER_PIXEL),
    localparam int WORD_W   = $clog2(WORDS)
)
(
    input  logic              I_CP_HCLK,
    input  logic              I_CP_HRESET_N,
    input  logic              dma_ready,
    input  logic              direction,
    input  rotate_pkg::deg_t  degrees,
    input  logic              read_active,
    input  logic              write_active,
    input  logic [ADDR_W-1:0] src_addr,
    input  logic [ADDR_W-1:0] dst_addr,
    input  logic [WORD_W-1:0] word_addr,
    input  string             test_name,
    input  logic              test_end,
    output int                error_count,
    output int                check_count,
    output int                test_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import rotate_pkg::*;

    phase_t    exp_phase = PH_IDLE;
    rot_mode_t exp_mode  = ROT_0;
    int        beat_k    = 0;
    int        errors    = 0;
    int        checks    = 0;
    int        tests     = 0;
    int        test_checks = 0;
    int        test_errors = 0;

    assign error_count = errors;
    assign check_count = checks;
    assign test_count  = tests;

    // direction high means counter-clockwise, so 270 one way is 90 the other
    function automatic rot_mode_t decode_mode(input deg_t deg, input logic ccw);
        case (deg)
            DEG_90:  decode_mode = ccw ? ROT_CCW90 : ROT_CW90;
            DEG_180: decode_mode = ROT_180;
            DEG_270: decode_mode = ccw ? ROT_CW90 : ROT_CCW90;
            default: decode_mode = ROT_0;
        endcase
    endfunction

    // output byte address of input pixel k
    function automatic int expected_dst(input rot_mode_t mode, input int k);
        int r;
        int c;
        r = k / TILE_DIM;
        c = k % TILE_DIM;
        case (mode)
            ROT_180:   expected_dst = BYTES_PER_PIXEL * (PIXELS - 1 - k);
            ROT_CW90:  expected_dst = BYTES_PER_PIXEL * (TILE_DIM * c + TILE_DIM - 1 - r);
            ROT_CCW90: expected_dst = BYTES_PER_PIXEL * (TILE_DIM * (TILE_DIM - 1 - c) + r);
            default:   expected_dst = BYTES_PER_PIXEL * k;
        endcase
    endfunction

    task automatic compare_value(input string what, input int expected, input int actual);
        checks++;
        test_checks++;
        if (expected != actual)
        begin
            errors++;
            test_errors++;
            $display("ERROR test %s: %s expected %0d actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    always @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N)
        begin
            exp_phase = PH_IDLE;
            exp_mode  = ROT_0;
            beat_k    = 0;
        end
        else
        begin
            // phase flags are checked in every cycle, gaps included
            compare_value("read_active", int'(exp_phase == PH_READ), int'(read_active));
            compare_value("write_active", int'(exp_phase == PH_WRITE), int'(write_active));
            case (exp_phase)
                PH_IDLE:
                begin
                    compare_value("idle src_addr", 0, int'(src_addr));
                    compare_value("idle dst_addr", 0, int'(dst_addr));
                    compare_value("idle word_addr", 0, int'(word_addr));
                    if (dma_ready)
                    begin
                        exp_mode  = decode_mode(degrees, direction);
                        exp_phase = PH_READ;
                        beat_k    = 0;
                    end
                end
                PH_READ:
                    if (dma_ready)
                    begin
                        compare_value($sformatf("src_addr beat %0d", beat_k),
                                      BYTES_PER_PIXEL * beat_k, int'(src_addr));
                        compare_value($sformatf("dst_addr beat %0d", beat_k),
                                      expected_dst(exp_mode, beat_k), int'(dst_addr));
                        if (beat_k == PIXELS - 1)
                        begin
                            exp_phase = PH_WRITE;
                            beat_k    = 0;
                        end
                        else
                            beat_k++;
                    end
                default:
                    if (dma_ready)
                    begin
                        compare_value($sformatf("word_addr beat %0d", beat_k),
                                      beat_k, int'(word_addr));
                        // the next tile's mode is taken on the last write beat
                        if (beat_k == WORDS - 1)
                        begin
                            exp_mode  = decode_mode(degrees, direction);
                            exp_phase = PH_READ;
                            beat_k    = 0;
                        end
                        else
                            beat_k++;
                    end
            endcase
            if (test_end)
            begin
                tests++;
                $display("test %s finished: %0d checks, %0d mismatches",
                         test_name, test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_rotate_addr_gen.sv */
// testbench top that runs the tile sequence through the rotation address generator and its checker
`default_nettype none

module tb_rotate_addr_gen;

    timeunit 1ns;
    timeprecision 1ps;

    import rotate_pkg::*;

    localparam int TILE_DIM   = 8;
    localparam int PIXELS     = TILE_DIM * TILE_DIM;
    localparam int WORDS      = PIXELS * BYTES_PER_PIXEL / WORD_BYTES;
    localparam int TILE_BEATS = PIXELS + WORDS;
    localparam int ADDR_W     = $clog2(PIXELS * BYTES_PER_PIXEL);
    localparam int WORD_W     = $clog2(WORDS);
    // eight tiles with up to three gap cycles per beat plus margin for reset and idle
    localparam int MAX_CYCLES = 8 * TILE_BEATS * 4 + 416;

    logic              I_CP_HCLK = 1'b0;
    logic              I_CP_HRESET_N;
    logic              dma_ready;
    logic              direction;
    deg_t              degrees;
    logic              read_active;
    logic              write_active;
    logic [ADDR_W-1:0] src_addr;
    logic [ADDR_W-1:0] dst_addr;
    logic [WORD_W-1:0] word_addr;
    string             test_name;
    logic              test_end;
    int                error_count;
    int                check_count;
    int                test_count;
    int                cycles = 0;

    rotate_addr_gen
    #(
        .TILE_DIM      (TILE_DIM)
    )
    i_dut
    (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .dma_ready     (dma_ready),
        .direction     (direction),
        .degrees       (degrees),
        .read_active   (read_active),
        .write_active  (write_active),
        .src_addr      (src_addr),
        .dst_addr      (dst_addr),
        .word_addr     (word_addr)
    );

    rotate_checker
    #(
        .TILE_DIM      (TILE_DIM)
    )
    u_checker
    (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .dma_ready     (dma_ready),
        .direction     (direction),
        .degrees       (degrees),
        .read_active   (read_active),
        .write_active  (write_active),
        .src_addr      (src_addr),
        .dst_addr      (dst_addr),
        .word_addr     (word_addr),
        .test_name     (test_name),
        .test_end      (test_end),
        .error_count   (error_count),
        .check_count   (check_count),
        .test_count    (test_count)
    );

    initial
    begin
        forever #20 I_CP_HCLK = ~I_CP_HCLK;
    end

    always @(posedge I_CP_HCLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    // one tile of beats with the next rotation set halfway through the read phase
    task automatic drive_tile(input deg_t next_deg, input logic next_ccw, input bit gaps);
        int beats;
        int gap;
        beats = 0;
        while (beats < TILE_BEATS)
        begin
            if (gaps)
            begin
                gap = int'($urandom % 4);
                repeat (gap)
                begin
                    @(negedge I_CP_HCLK);
                    dma_ready = 1'b0;
                end
            end
            @(negedge I_CP_HCLK);
            dma_ready = 1'b1;
            beats++;
            if (beats == PIXELS / 2)
            begin
                degrees   = next_deg;
                direction = next_ccw;
            end
        end
    endtask

    // pause the DMA and tell the checker the test is over
    task automatic end_test();
        @(negedge I_CP_HCLK);
        dma_ready = 1'b0;
        test_end  = 1'b1;
        @(negedge I_CP_HCLK);
        test_end  = 1'b0;
    endtask

    initial
    begin
        dma_ready     = 1'b0;
        direction     = 1'b0;
        degrees       = DEG_0;
        test_end      = 1'b0;
        test_name     = "reset_idle";
        I_CP_HRESET_N = 1'b0;
        void'($urandom(7));
        repeat (16) @(negedge I_CP_HCLK);
        I_CP_HRESET_N = 1'b1;
        repeat (8) @(negedge I_CP_HCLK);
        end_test();

        // idle exit samples 0 degrees
        test_name = "rot0_gap_free";
        @(negedge I_CP_HCLK);
        dma_ready = 1'b1;
        drive_tile(DEG_180, 1'b0, 1'b0);
        end_test();

        test_name = "rot180_both_directions";
        drive_tile(DEG_180, 1'b1, 1'b0);
        drive_tile(DEG_90, 1'b0, 1'b0);
        end_test();

        // cw 90 then ccw 270 give the same addresses
        test_name = "cw90_and_ccw270";
        drive_tile(DEG_270, 1'b1, 1'b0);
        drive_tile(DEG_90, 1'b1, 1'b0);
        end_test();

        test_name = "ccw90_random_gaps";
        drive_tile(DEG_0, 1'b0, 1'b1);
        end_test();

        // 0 degree tile sees 270 arrive mid read so the next tile is ccw
        test_name = "mid_tile_change";
        drive_tile(DEG_270, 1'b0, 1'b0);
        drive_tile(DEG_0, 1'b0, 1'b0);
        end_test();

        $display("tests %0d, checks %0d, mismatches %0d", test_count, check_count, error_count);
        if (error_count == 0 && check_count > 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* rotate_addr_gen.f */
hdl/rotate_pkg.sv
hdl/tile_sequencer.sv
hdl/pixel_addr_rotator.sv
hdl/rotate_addr_gen.sv
tb/rotate_checker.sv
tb/tb_rotate_addr_gen.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and decides pass or fail from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --top-module tb_rotate_addr_gen -f rotate_addr_gen.f -o sim_rotate
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_rotate > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if [ ! -s "$LOG" ]; then
    echo "simulation log is empty"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0
